/* source/tut_consts.svh */
// Tutankham video board constants for the bus address map and the raster timing
`ifndef TUT_CONSTS_SVH
`define TUT_CONSTS_SVH

// ==========================================================================
// Address map
// ==========================================================================

// Video RAM fills the lower 32 KB of the bus space
`define TUT_VRAM_AW 15

// Upper address bits that select each register page
`define TUT_PAL_PAGE 12'h800
`define TUT_SCROLL_PAGE 12'h810
`define TUT_LATCH_PAGE 13'h1040

// Control latch bits picked by address bits 2:0
`define TUT_LATCH_IRQ_EN 3'd0
`define TUT_LATCH_FLIP_X 3'd6
`define TUT_LATCH_FLIP_Y 3'd7

// Byte returned for write-only and unmapped reads
`define TUT_OPEN_BUS 8'hFF

// ==========================================================================
// Raster timing
// ==========================================================================

// Master clocks per pixel
`define TUT_CEN_DIV 8

// Horizontal count runs 128..511 and blanks strictly between the two limits
`define TUT_H_FIRST 128
`define TUT_H_LAST 511
`define TUT_HBLK_LO 140
`define TUT_HBLK_HI 269
`define TUT_HSYNC_LO 176
`define TUT_HSYNC_HI 207

// Vertical count runs 0..263 with vblank outside lines 16..239
`define TUT_V_LINES 264
`define TUT_VBLK_END 16
`define TUT_VBLK_START 240
`define TUT_VSYNC_LINES 8

// Only the left part of the playfield follows the scroll register
`define TUT_SCROLL_COLS 192

`endif

/* source/tut_pkg.sv */
// Shared data types for the Tutankham CPU bus and the bitmap video path
`include "tut_consts.svh"

package tut_pkg;

	// CPU side
	typedef logic [15:0] bus_addr_t;
	typedef logic [7:0] byte_t;

	// Raster counters as they leave the timing block
	typedef logic [8:0] hcount_t;
	typedef logic [8:0] vcount_t;

	// Video RAM holds two 4-bit pixels per byte
	typedef logic [`TUT_VRAM_AW-1:0] vram_addr_t;
	typedef logic [3:0] pal_index_t;

	// One output colour channel
	typedef logic [4:0] rgb5_t;

	// A palette byte is plain data on the bus side
	// The scanout reads the same byte as BBGGGRRR
	typedef union packed {
		byte_t raw;
		struct packed {
			logic [1:0] blue;
			logic [2:0] green;
			logic [2:0] red;
		} colour;
	} pal_entry_t;

endpackage

/* source/cpu_bus_regs.sv */
// CPU bus slave with palette file, scroll register, control latch, read mux and vblank IRQ
`include "tut_consts.svh"

module cpu_bus_regs (
	input  logic                clk_49m,
	input  logic                reset,
	input  tut_pkg::bus_addr_t  addr_i,
	input  tut_pkg::byte_t      wdata_i,
	input  logic                wr_i,
	input  logic                rd_i,
	input  tut_pkg::byte_t      vram_rdata_i,
	output logic                vram_we_o,
	output tut_pkg::byte_t      rdata_o,
	output logic                rd_valid_o,
	input  logic                vblank_i,
	input  tut_pkg::pal_index_t pal_index_i,
	output tut_pkg::pal_entry_t pal_entry_o,
	output tut_pkg::byte_t      scroll_o,
	output logic                flip_x_o,
	output logic                flip_y_o,
	output logic                irq_n_o
);
	import tut_pkg::*;

	// Source of the byte that a read returns one cycle later
	localparam logic [1:0] RD_VRAM = 2'd0;
	localparam logic [1:0] RD_PAL = 2'd1;
	localparam logic [1:0] RD_SCROLL = 2'd2;
	localparam logic [1:0] RD_OPEN = 2'd3;

	logic       sel_vram;
	logic       sel_pal;
	logic       sel_scroll;
	logic       sel_latch;
	logic [1:0] rd_region;
	logic [1:0] rd_region_q;
	pal_index_t rd_pal_idx_q;
	pal_entry_t palette_q [16];
	logic       irq_en_q;
	logic       irq_phase_q;
	logic       vblank_q;

	// ==========================================================================
	// Address decode
	// ==========================================================================

	// A15 low selects video RAM and the register pages sit at 0x80xx..0x82xx
	assign sel_vram = !addr_i[15];
	assign sel_pal = (addr_i[15:4] == `TUT_PAL_PAGE);
	assign sel_scroll = (addr_i[15:4] == `TUT_SCROLL_PAGE);
	assign sel_latch = (addr_i[15:3] == `TUT_LATCH_PAGE);

	assign vram_we_o = wr_i && sel_vram;

	// The latch page is write only so it falls into open bus with the unmapped space
	always_comb begin
		if (sel_vram) begin
			rd_region = RD_VRAM;
		end else if (sel_pal) begin
			rd_region = RD_PAL;
		end else if (sel_scroll) begin
			rd_region = RD_SCROLL;
		end else begin
			rd_region = RD_OPEN;
		end
	end

	// ==========================================================================
	// Palette, scroll and control latch
	// ==========================================================================

	// Sixteen BBGGGRRR entries held in flops so the bus and the scanout read at once
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			for (int i = 0; i < 16; i++) begin
				palette_q[i] <= '0;
			end
		end else if (wr_i && sel_pal) begin
			palette_q[addr_i[3:0]].raw <= wdata_i;
		end
	end

	// The scanout index arrives from the RAM nibble and is looked up combinationally
	assign pal_entry_o = palette_q[pal_index_i];

	// Addressable latch where data bit 0 lands in the bit chosen by A2..A0
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			scroll_o <= '0;
			irq_en_q <= 1'b0;
			flip_x_o <= 1'b0;
			flip_y_o <= 1'b0;
		end else begin
			if (wr_i && sel_scroll) begin
				scroll_o <= wdata_i;
			end
			if (wr_i && sel_latch) begin
				case (addr_i[2:0])
					`TUT_LATCH_IRQ_EN: irq_en_q <= wdata_i[0];
					`TUT_LATCH_FLIP_X: flip_x_o <= wdata_i[0];
					`TUT_LATCH_FLIP_Y: flip_y_o <= wdata_i[0];
					// Remaining bits drove coin counters and sound mute on the real board
					default: ;
				endcase
			end
		end
	end

	// ==========================================================================
	// Read return
	// ==========================================================================

	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			rd_valid_o <= 1'b0;
		end else begin
			rd_valid_o <= rd_i;
		end
	end

	// Remember where the read went, the RAM byte itself comes from port A a cycle later
	always_ff @(posedge clk_49m) begin
		if (rd_i) begin
			rd_region_q <= rd_region;
			rd_pal_idx_q <= addr_i[3:0];
		end
	end

	always_comb begin
		case (rd_region_q)
			RD_VRAM:   rdata_o = vram_rdata_i;
			RD_PAL:    rdata_o = palette_q[rd_pal_idx_q].raw;
			RD_SCROLL: rdata_o = scroll_o;
			default:   rdata_o = `TUT_OPEN_BUS;
		endcase
	end

	// ==========================================================================
	// Vblank interrupt
	// ==========================================================================

	// Phase toggles on each vblank rise so only every second frame interrupts
	// The line stays low until software clears IRQ enable
	// vblank_q starts high so the first line after reset is not seen as an edge
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			vblank_q <= 1'b1;
			irq_phase_q <= 1'b0;
			irq_n_o <= 1'b1;
		end else begin
			vblank_q <= vblank_i;
			if (!irq_en_q) begin
				irq_n_o <= 1'b1;
			end else if (vblank_i && !vblank_q) begin
				irq_phase_q <= !irq_phase_q;
				if (!irq_phase_q) begin
					irq_n_o <= 1'b0;
				end
			end
		end
	end

endmodule

/* source/video_ram.sv */
// Dual-port 32 KB video RAM with a CPU read/write port and a scanout read port
`include "tut_consts.svh"

module video_ram (
	input  logic                clk_49m,
	input  tut_pkg::vram_addr_t a_addr_i,
	input  tut_pkg::byte_t      a_wdata_i,
	input  logic                a_we_i,
	output tut_pkg::byte_t      a_rdata_o,
	input  tut_pkg::vram_addr_t b_addr_i,
	output tut_pkg::byte_t      b_rdata_o
);
	import tut_pkg::*;

	localparam int DEPTH = 2 ** `TUT_VRAM_AW;

	// Block RAM comes up cleared and keeps its contents across reset
	byte_t mem [DEPTH] = '{default: '0};

	// Port A is the CPU side
	// A write and a read never share a cycle so read-during-write order is unused
	always_ff @(posedge clk_49m) begin
		if (a_we_i) begin
			mem[a_addr_i] <= a_wdata_i;
		end
		a_rdata_o <= mem[a_addr_i];
	end

	// Port B only reads and follows the scanout address every clock
	always_ff @(posedge clk_49m) begin
		b_rdata_o <= mem[b_addr_i];
	end

endmodule

/* source/video_timing.sv */
// Raster timing generator with pixel enable, H/V counters, blanking and sync
`include "tut_consts.svh"

module video_timing (
	input  logic             clk_49m,
	input  logic             reset,
	output logic             cen_o,
	output tut_pkg::hcount_t h_cnt_o,
	output tut_pkg::vcount_t v_cnt_o,
	output logic             hblank_o,
	output logic             vblank_o,
	output logic             hsync_n_o,
	output logic             vsync_n_o
);
	import tut_pkg::*;

	localparam int DIV_W = $clog2(`TUT_CEN_DIV);

	logic [DIV_W-1:0] div_q;
	hcount_t          h_q;
	vcount_t          v_q;

	// ==========================================================================
	// Pixel enable
	// ==========================================================================

	// 49.152 MHz divided by eight gives the 6.144 MHz dot rate
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			div_q <= '0;
		end else if (div_q == DIV_W'(`TUT_CEN_DIV - 1)) begin
			div_q <= '0;
		end else begin
			div_q <= div_q + DIV_W'(1);
		end
	end

	// One clock in eight, including the first clock after reset
	assign cen_o = (div_q == '0);

	// ==========================================================================
	// Counters
	// ==========================================================================

	// H runs 128..511 so bit 8 marks the right-hand half of the line
	// V steps once per line on the H wrap
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			h_q <= hcount_t'(`TUT_H_FIRST);
			v_q <= '0;
		end else if (cen_o) begin
			if (h_q == hcount_t'(`TUT_H_LAST)) begin
				h_q <= hcount_t'(`TUT_H_FIRST);
				if (v_q == vcount_t'(`TUT_V_LINES - 1)) begin
					v_q <= '0;
				end else begin
					v_q <= v_q + vcount_t'(1);
				end
			end else begin
				h_q <= h_q + hcount_t'(1);
			end
		end
	end

	assign h_cnt_o = h_q;
	assign v_cnt_o = v_q;

	// Blanking and sync windows decoded straight from the counter flops
	assign hblank_o = (h_q > hcount_t'(`TUT_HBLK_LO)) && (h_q < hcount_t'(`TUT_HBLK_HI));
	assign hsync_n_o = !((h_q >= hcount_t'(`TUT_HSYNC_LO)) && (h_q <= hcount_t'(`TUT_HSYNC_HI)));
	assign vblank_o = (v_q < vcount_t'(`TUT_VBLK_END)) || (v_q >= vcount_t'(`TUT_VBLK_START));
	assign vsync_n_o = !(v_q < vcount_t'(`TUT_VSYNC_LINES));

endmodule

/* source/scanout.sv */
// Bitmap scanout applying flip and scroll, picking the nibble and expanding palette colour
`include "tut_consts.svh"

module scanout (
	input  logic                 clk_49m,
	input  logic                 reset,
	input  logic                 cen_i,
	input  tut_pkg::hcount_t     h_cnt_i,
	input  tut_pkg::vcount_t     v_cnt_i,
	input  logic                 hblank_i,
	input  logic                 vblank_i,
	input  logic                 hsync_n_i,
	input  logic                 vsync_n_i,
	input  logic                 flip_x_i,
	input  logic                 flip_y_i,
	input  tut_pkg::byte_t       scroll_i,
	output tut_pkg::vram_addr_t  vram_addr_o,
	input  tut_pkg::byte_t       vram_data_i,
	output tut_pkg::pal_index_t  pal_index_o,
	input  tut_pkg::pal_entry_t  pal_entry_i,
	output tut_pkg::rgb5_t       red_o,
	output tut_pkg::rgb5_t       green_o,
	output tut_pkg::rgb5_t       blue_o,
	output logic                 hblank_o,
	output logic                 vblank_o,
	output logic                 hsync_n_o,
	output logic                 vsync_n_o,
	output logic                 ce_pix_o
);
	import tut_pkg::*;

	// Visible line runs from H 269 up to 511 and then wraps through 128..140
	localparam int PIX_OFS_HI = `TUT_HBLK_HI - 256;
	localparam int PIX_OFS_LO = 512 - `TUT_HBLK_HI - `TUT_H_FIRST;

	byte_t pix_x;
	byte_t eff_x;
	byte_t eff_y;
	byte_t scroll_add;
	logic  blank;
	logic  ce_d1_q;
	logic  ce_d2_q;
	logic  nib_hi_q;

	// Map the counter to a continuous 0..255 screen column
	always_comb begin
		if (h_cnt_i[8]) begin
			pix_x = h_cnt_i[7:0] - 8'(PIX_OFS_HI);
		end else begin
			pix_x = h_cnt_i[7:0] + 8'(PIX_OFS_LO);
		end
	end

	// Flip inverts the coordinate and the right-hand status area never scrolls
	assign eff_x = pix_x ^ {8{flip_x_i}};
	assign scroll_add = (eff_x < 8'(`TUT_SCROLL_COLS)) ? scroll_i : 8'd0;
	assign eff_y = (v_cnt_i[7:0] ^ {8{flip_y_i}}) + scroll_add;

	// 128 bytes per row with two pixels in each byte
	assign vram_addr_o = {eff_y, eff_x[7:1]};

	// Odd columns live in the upper nibble
	assign pal_index_o = nib_hi_q ? vram_data_i[7:4] : vram_data_i[3:0];
	assign blank = hblank_i || vblank_i;

	// Enable pipeline that tracks the RAM read and then the output register
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			ce_d1_q <= 1'b0;
			ce_d2_q <= 1'b0;
			ce_pix_o <= 1'b0;
			hblank_o <= 1'b1;
			vblank_o <= 1'b1;
			hsync_n_o <= 1'b1;
			vsync_n_o <= 1'b1;
		end else begin
			ce_d1_q <= cen_i;
			ce_d2_q <= ce_d1_q;
			ce_pix_o <= ce_d2_q;
			if (ce_d2_q) begin
				hblank_o <= hblank_i;
				vblank_o <= vblank_i;
				hsync_n_o <= hsync_n_i;
				vsync_n_o <= vsync_n_i;
			end
		end
	end

	// Nibble select is taken with the RAM read so it matches the returned byte
	always_ff @(posedge clk_49m) begin
		if (ce_d1_q) begin
			nib_hi_q <= eff_x[0];
		end
		if (ce_d2_q) begin
			// Repeat the top bits to reach 5 bits so full scale stays full scale
			red_o <= blank ? '0 : {pal_entry_i.colour.red, pal_entry_i.colour.red[2:1]};
			green_o <= blank ? '0 : {pal_entry_i.colour.green, pal_entry_i.colour.green[2:1]};
			blue_o <= blank ? '0 : {pal_entry_i.colour.blue, pal_entry_i.colour.blue,
				pal_entry_i.colour.blue[1]};
		end
	end

endmodule

/* source/tut_video_top.sv */
// Tutankham video board top level joining the bus registers, video RAM, timing and scanout
`include "tut_consts.svh"

module tut_video_top (
	input  logic               clk_49m,
	input  logic               reset,
	input  tut_pkg::bus_addr_t addr_i,
	input  tut_pkg::byte_t     wdata_i,
	input  logic               wr_i,
	input  logic               rd_i,
	output tut_pkg::byte_t     rdata_o,
	output logic               rd_valid_o,
	output tut_pkg::rgb5_t     red_o,
	output tut_pkg::rgb5_t     green_o,
	output tut_pkg::rgb5_t     blue_o,
	output logic               hblank_o,
	output logic               vblank_o,
	output logic               hsync_n_o,
	output logic               vsync_n_o,
	output logic               ce_pix_o,
	output logic               irq_n_o
);
	import tut_pkg::*;

	// Video RAM port A belongs to the CPU and port B to the scanout
	logic       vram_we;
	byte_t      vram_a_rdata;
	vram_addr_t vram_b_addr;
	byte_t      vram_b_rdata;

	// Raster state from the timing generator
	logic    cen;
	hcount_t h_cnt;
	vcount_t v_cnt;
	logic    hblank;
	logic    vblank;
	logic    hsync_n;
	logic    vsync_n;

	// Palette lookup and latch values seen by the scanout
	pal_index_t pal_index;
	pal_entry_t pal_entry;
	byte_t      scroll;
	logic       flip_x;
	logic       flip_y;

	cpu_bus_regs u_bus_regs (
		.clk_49m      (clk_49m),
		.reset        (reset),
		.addr_i       (addr_i),
		.wdata_i      (wdata_i),
		.wr_i         (wr_i),
		.rd_i         (rd_i),
		.vram_rdata_i (vram_a_rdata),
		.vram_we_o    (vram_we),
		.rdata_o      (rdata_o),
		.rd_valid_o   (rd_valid_o),
		.vblank_i     (vblank),
		.pal_index_i  (pal_index),
		.pal_entry_o  (pal_entry),
		.scroll_o     (scroll),
		.flip_x_o     (flip_x),
		.flip_y_o     (flip_y),
		.irq_n_o      (irq_n_o)
	);

	// The CPU address and data go straight to port A
	video_ram u_video_ram (
		.clk_49m   (clk_49m),
		.a_addr_i  (addr_i[`TUT_VRAM_AW-1:0]),
		.a_wdata_i (wdata_i),
		.a_we_i    (vram_we),
		.a_rdata_o (vram_a_rdata),
		.b_addr_i  (vram_b_addr),
		.b_rdata_o (vram_b_rdata)
	);

	video_timing u_video_timing (
		.clk_49m   (clk_49m),
		.reset     (reset),
		.cen_o     (cen),
		.h_cnt_o   (h_cnt),
		.v_cnt_o   (v_cnt),
		.hblank_o  (hblank),
		.vblank_o  (vblank),
		.hsync_n_o (hsync_n),
		.vsync_n_o (vsync_n)
	);

	scanout u_scanout (
		.clk_49m     (clk_49m),
		.reset       (reset),
		.cen_i       (cen),
		.h_cnt_i     (h_cnt),
		.v_cnt_i     (v_cnt),
		.hblank_i    (hblank),
		.vblank_i    (vblank),
		.hsync_n_i   (hsync_n),
		.vsync_n_i   (vsync_n),
		.flip_x_i    (flip_x),
		.flip_y_i    (flip_y),
		.scroll_i    (scroll),
		.vram_addr_o (vram_b_addr),
		.vram_data_i (vram_b_rdata),
		.pal_index_o (pal_index),
		.pal_entry_i (pal_entry),
		.red_o       (red_o),
		.green_o     (green_o),
		.blue_o      (blue_o),
		.hblank_o    (hblank_o),
		.vblank_o    (vblank_o),
		.hsync_n_o   (hsync_n_o),
		.vsync_n_o   (vsync_n_o),
		.ce_pix_o    (ce_pix_o)
	);

endmodule

/* dv/tb_checks.sv */
// Video board scoreboard with bus, raster, pixel colour and interrupt assertions
module tb_checks (
	input  logic        clk_49m,
	input  logic        reset,
	input  logic [15:0] addr_i,
	input  logic [7:0]  wdata_i,
	input  logic        wr_i,
	input  logic        rd_i,
	input  logic [7:0]  rdata_i,
	input  logic        rd_valid_i,
	input  logic [4:0]  red_i,
	input  logic [4:0]  green_i,
	input  logic [4:0]  blue_i,
	input  logic        hblank_i,
	input  logic        vblank_i,
	input  logic        hsync_n_i,
	input  logic        vsync_n_i,
	input  logic        ce_pix_i,
	input  logic        irq_n_i,
	output int          errors_o,
	output int          pixels_o,
	output int          irq_falls_o
);
	timeunit 1ns;
	timeprecision 100ps;

	// Reference copies of everything the CPU has written
	logic [7:0] vmem [32768];
	logic [7:0] pal [16];
	logic [7:0] scroll;
	logic       irq_en;
	logic       flip_x;
	logic       flip_y;

	// Read return, pixel tracker and interrupt bookkeeping
	logic       rd_pend;
	logic [7:0] rd_exp;
	logic [15:0] rd_addr;
	int         quiet;
	int         n;
	logic       tracking;
	logic       prev_vb;
	logic       prev_irq;
	logic       fall_pend;
	logic       irq_phase;
	int         en_off_cnt;

	initial begin
		errors_o = 0;
		pixels_o = 0;
		irq_falls_o = 0;
		for (int i = 0; i < 32768; i++) begin
			vmem[i] = 8'h00;
		end
	end

	task automatic report_fail(input string msg);
		$display("Fail %0t: %s", $time, msg);
		errors_o++;
	endtask

	// Address map as seen from the bus with RAM, palette, scroll and open bus
	function automatic logic [7:0] expected_read(input logic [15:0] a);
		if (!a[15]) begin
			return vmem[a[14:0]];
		end else if (a[15:4] == 12'h800) begin
			return pal[a[3:0]];
		end else if (a[15:4] == 12'h810) begin
			return scroll;
		end
		return 8'hFF;
	endfunction

	// Colour of the pixel at counter h on line v, built from the flip, scroll and palette rules
	function automatic logic [14:0] expected_rgb(input int h, input int v);
		logic [7:0] px;
		logic [7:0] ex;
		logic [7:0] ey;
		logic [7:0] b;
		logic [7:0] e;
		logic [3:0] idx;
		px = (h >= 256) ? 8'(h - 269) : 8'(h + 115);
		ex = flip_x ? ~px : px;
		ey = flip_y ? ~8'(v) : 8'(v);
		if (ex < 8'd192) begin
			ey = ey + scroll;
		end
		b = vmem[{ey, ex[7:1]}];
		idx = ex[0] ? b[7:4] : b[3:0];
		e = pal[idx];
		// Channels are red in bits 2:0, green in 5:3 and blue in 7:6
		return {e[2:0], e[2:1], e[5:3], e[5:4], e[7:6], e[7:6], e[7]};
	endfunction

	// ==========================================================================
	// Bus handshake with one cycle read latency
	// ==========================================================================

	read_valid_follows: assert property (@(posedge clk_49m) disable iff (!reset)
		rd_i |=> rd_valid_i)
		else report_fail("rd_valid_o missing one cycle after a read");

	no_stray_valid: assert property (@(posedge clk_49m) disable iff (!reset)
		!rd_i |=> !rd_valid_i)
		else report_fail("rd_valid_o high without a read");

	// ==========================================================================
	// Scoreboard
	// ==========================================================================

	always @(posedge clk_49m) begin
		if (!reset) begin
			for (int i = 0; i < 16; i++) begin
				pal[i] = 8'h00;
			end
			scroll = 8'h00;
			irq_en = 1'b0;
			flip_x = 1'b0;
			flip_y = 1'b0;
			rd_pend = 1'b0;
			quiet = 0;
			n = 0;
			tracking = 1'b0;
			prev_vb = 1'b1;
			prev_irq = 1'b1;
			fall_pend = 1'b0;
			irq_phase = 1'b0;
			en_off_cnt = 0;
		end else begin
			// Data for the read issued on the previous edge
			if (rd_pend) begin
				assert (rdata_i == rd_exp)
					else report_fail($sformatf("read of %h gave %h, expected %h",
						rd_addr, rdata_i, rd_exp));
			end
			rd_pend = rd_i;
			if (rd_i) begin
				rd_exp = expected_read(addr_i);
				rd_addr = addr_i;
			end

			// A falling interrupt line is held until the next vblank rise judges it
			if (prev_irq && !irq_n_i) begin
				fall_pend = 1'b1;
				irq_falls_o++;
			end
			prev_irq = irq_n_i;

			// With IRQ enable clear the line must go and stay high
			en_off_cnt = irq_en ? 0 : en_off_cnt + 1;
			if (en_off_cnt >= 3) begin
				assert (irq_n_i)
					else report_fail("irq_n_o low while IRQ enable is clear");
			end

			if (ce_pix_i) begin
				// Interrupt only on every second vblank rise
				if (!prev_vb && vblank_i) begin
					assert (fall_pend == (irq_en && !irq_phase))
						else report_fail($sformatf("irq fall %b at vblank, phase %b",
							fall_pend, irq_phase));
					if (irq_en) begin
						irq_phase = !irq_phase;
					end
					fall_pend = 1'b0;
				end

				// Sample count since vblank ended gives h and v
				if (prev_vb && !vblank_i) begin
					n = 0;
					tracking = 1'b1;
				end else begin
					n++;
				end
				prev_vb = vblank_i;

				// Blanked samples carry no colour
				if (hblank_i || vblank_i) begin
					assert (red_i == 5'd0 && green_i == 5'd0 && blue_i == 5'd0)
						else report_fail($sformatf("colour %h %h %h during blank",
							red_i, green_i, blue_i));
				end

				if (tracking) begin
					int h;
					int v;
					h = 128 + (n % 384);
					v = (16 + n / 384) % 264;
					assert (hblank_i == (h > 140 && h < 269)
						&& vblank_i == (v < 16 || v >= 240)
						&& hsync_n_i == !(h >= 176 && h <= 207)
						&& vsync_n_i == !(v < 8))
						else report_fail($sformatf("blank or sync wrong at h %0d v %0d", h, v));
					// Pixels right after a write may still show the old state
					if (!hblank_i && !vblank_i && quiet >= 8) begin
						assert ({red_i, green_i, blue_i} == expected_rgb(h, v))
							else report_fail($sformatf("pixel h %0d v %0d is %h, expected %h",
								h, v, {red_i, green_i, blue_i}, expected_rgb(h, v)));
						pixels_o++;
					end
				end
			end

			// The model follows the write that the DUT takes at this edge
			if (wr_i) begin
				quiet = 0;
				if (!addr_i[15]) begin
					vmem[addr_i[14:0]] = wdata_i;
				end else if (addr_i[15:4] == 12'h800) begin
					pal[addr_i[3:0]] = wdata_i;
				end else if (addr_i[15:4] == 12'h810) begin
					scroll = wdata_i;
				end else if (addr_i[15:3] == 13'h1040) begin
					case (addr_i[2:0])
						3'd0: irq_en = wdata_i[0];
						3'd6: flip_x = wdata_i[0];
						3'd7: flip_y = wdata_i[0];
						default: ;
					endcase
				end
			end else if (quiet < 100) begin
				quiet++;
			end
		end
	end

endmodule

/* dv/tb_top.sv */
// Video board testbench driving the CPU bus and running the test sequence
module tb_top;
	timeunit 1ns;
	timeprecision 100ps;

	// One frame is 384 pixels by 264 lines at 8 clocks per pixel
	localparam int FRAME_CYCLES = 384 * 264 * 8;
	localparam int CYCLE_LIMIT = 5 * FRAME_CYCLES + 10000;

	logic        clk_49m;
	logic        reset;
	logic [15:0] addr;
	logic [7:0]  wdata;
	logic        wr;
	logic        rd;
	logic [7:0]  rdata;
	logic        rd_valid;
	logic [4:0]  red;
	logic [4:0]  green;
	logic [4:0]  blue;
	logic        hblank;
	logic        vblank;
	logic        hsync_n;
	logic        vsync_n;
	logic        ce_pix;
	logic        irq_n;

	int          errors;
	int          pixels;
	int          irq_falls;
	int          cycles;
	int          tests_run;
	int          tests_failed;
	logic [31:0] lcg_state;

	tut_video_top dut (
		.clk_49m(clk_49m), .reset(reset), .addr_i(addr), .wdata_i(wdata),
		.wr_i(wr), .rd_i(rd), .rdata_o(rdata), .rd_valid_o(rd_valid),
		.red_o(red), .green_o(green), .blue_o(blue), .hblank_o(hblank),
		.vblank_o(vblank), .hsync_n_o(hsync_n), .vsync_n_o(vsync_n),
		.ce_pix_o(ce_pix), .irq_n_o(irq_n)
	);

	tb_checks checks (
		.clk_49m(clk_49m), .reset(reset), .addr_i(addr), .wdata_i(wdata),
		.wr_i(wr), .rd_i(rd), .rdata_i(rdata), .rd_valid_i(rd_valid),
		.red_i(red), .green_i(green), .blue_i(blue), .hblank_i(hblank),
		.vblank_i(vblank), .hsync_n_i(hsync_n), .vsync_n_i(vsync_n),
		.ce_pix_i(ce_pix), .irq_n_i(irq_n), .errors_o(errors), .pixels_o(pixels),
		.irq_falls_o(irq_falls)
	);

	initial begin
		clk_49m = 1'b0;
		forever #5 clk_49m = !clk_49m;
	end

	// Hard stop a little over five frames as the sequence spans nearly five
	always @(posedge clk_49m) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TEST FAILED");
			$finish;
		end
	end

	function automatic logic [7:0] random_byte();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[23:16];
	endfunction

	// Bus cycles start 1 ns after an edge and last one clock
	task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
		addr = a;
		wdata = d;
		wr = 1'b1;
		@(posedge clk_49m);
		#1;
		wr = 1'b0;
	endtask

	task automatic bus_read(input logic [15:0] a);
		addr = a;
		rd = 1'b1;
		@(posedge clk_49m);
		#1;
		rd = 1'b0;
	endtask

	task automatic idle(input int n);
		repeat (n) @(posedge clk_49m);
		#1;
	endtask

	// Returns just after the pixel stream enters vblank following an active area
	task automatic wait_vblank_rise();
		logic seen_low;
		logic done;
		seen_low = 1'b0;
		done = 1'b0;
		while (!done) begin
			@(posedge clk_49m);
			if (ce_pix && !vblank) begin
				seen_low = 1'b1;
			end else if (ce_pix && vblank && seen_low) begin
				done = 1'b1;
			end
		end
		#1;
	endtask

	// Re-arm the interrupt, clearing the line but keeping the phase
	task automatic rearm_irq();
		bus_write(16'h8200, 8'h00);
		idle(4);
		bus_write(16'h8200, 8'h01);
	endtask

	task automatic finish_test(input string name, input int err_before, input logic ok);
		tests_run++;
		if (errors != err_before || !ok) begin
			tests_failed++;
			$display("%s: failed, %0d check errors", name, errors - err_before);
		end else begin
			$display("%s: ok", name);
		end
	endtask

	initial begin
		int          e0;
		int          p0;
		logic [14:0] ram_a [8];
		logic [7:0]  addr_hi;
		logic [7:0]  addr_lo;
		reset = 1'b0;
		addr = 16'h0000;
		wdata = 8'h00;
		wr = 1'b0;
		rd = 1'b0;
		cycles = 0;
		tests_run = 0;
		tests_failed = 0;
		lcg_state = 32'ha2ad_7121;
		repeat (3) @(posedge clk_49m);
		#1;
		reset = 1'b1;

		// Readback runs inside the first vblank
		e0 = errors;
		for (int i = 0; i < 16; i++) begin
			bus_write(16'h8000 + 16'(i), random_byte());
			bus_read(16'h8000 + 16'(i));
		end
		bus_write(16'h8100, random_byte());
		bus_read(16'h8100);
		bus_read(16'h810F);
		for (int i = 0; i < 8; i++) begin
			addr_hi = random_byte();
			addr_lo = random_byte();
			ram_a[i] = {addr_hi[6:0], addr_lo};
			bus_write({1'b0, ram_a[i]}, random_byte());
			bus_read({1'b0, ram_a[i]});
		end
		bus_read(16'h8200);
		bus_read(16'h8206);
		bus_read(16'h8010);
		bus_read(16'h8300);
		bus_read(16'hC000);
		for (int i = 0; i < 8; i++) begin
			bus_write({1'b0, ram_a[i]}, 8'h00);
		end
		bus_write(16'h8100, 8'h00);
		idle(2);
		finish_test("register readback", e0, 1'b1);

		// RAM is zero so every active pixel shows palette entry 0
		e0 = errors;
		p0 = pixels;
		bus_write(16'h8000, random_byte());
		bus_write(16'h8200, 8'h01);
		wait_vblank_rise();
		finish_test("blanking", e0, 1'b1);
		finish_test("palette colour", e0, pixels > p0);

		// Marked bytes with distinct nibbles and palette entries
		e0 = errors;
		rearm_irq();
		for (int i = 1; i < 7; i++) begin
			bus_write(16'h8000 + 16'(i), random_byte());
		end
		bus_write(16'(40 * 128 + 10), 8'h21);
		bus_write(16'(100 * 128 + 60), 8'h43);
		bus_write(16'(200 * 128 + 120), 8'h65);
		wait_vblank_rise();
		bus_write(16'h8206, 8'h01);
		bus_write(16'h8207, 8'h01);
		rearm_irq();
		wait_vblank_rise();
		finish_test("address, nibble and flip", e0, 1'b1);

		// Scroll moves the marked bytes only left of column 192
		e0 = errors;
		bus_write(16'h8206, 8'h00);
		bus_write(16'h8207, 8'h00);
		bus_write(16'h8100, random_byte() | 8'h01);
		rearm_irq();
		wait_vblank_rise();
		finish_test("scroll", e0, 1'b1);

		// The interrupt fell on the first and third of four enabled vblank rises
		// A fifth rise with IRQ enable clear must leave the line high
		e0 = errors;
		bus_write(16'h8200, 8'h00);
		wait_vblank_rise();
		idle(20);
		assert (irq_falls == 2)
			else $display("Fail %0t: expected two irq_n_o falls but saw %0d",
				$time, irq_falls);
		finish_test("interrupt", e0, irq_falls == 2);

		$display("Summary: %0d tests, %0d failed, %0d check errors, %0d pixels checked",
			tests_run, tests_failed, errors, pixels);
		if (tests_failed == 0 && errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* project.f */
+incdir+source
source/tut_pkg.sv
source/cpu_bus_regs.sv
source/video_ram.sv
source/video_timing.sv
source/scanout.sv
source/tut_video_top.sv
dv/tb_checks.sv
dv/tb_top.sv

/* Makefile */
# Verilator build and run for the video board testbench

.PHONY: all run lint clean

all: run

obj_dir/Vtb_top: project.f $(wildcard source/*.sv source/*.svh dv/*.sv)
	verilator --binary --timing --assert -j 0 --top-module tb_top -f project.f -o Vtb_top

run: obj_dir/Vtb_top
	./obj_dir/Vtb_top | tee sim.log
	grep -q "^TEST PASSED$$" sim.log

lint:
	verilator --lint-only --timing --assert --top-module tb_top -f project.f

clean:
	rm -rf obj_dir sim.log
